// ==== design/rvIsaPkg.sv ====
package rvIsaPkg;

	// Integer register width of RV32I
	localparam int xlen = 32;

	// Architectural register number, five bits in the encoding
	localparam int regAddrW = 5;

	// Immediate shift amount field of SLLI, SRLI and SRAI
	localparam int shiftAmtW = 5;

	// One data value as held in a register
	typedef logic [xlen-1:0] word;

	// Register number as it comes out of the instruction word
	// Only the low bits matter for the 16-register variant
	typedef logic [regAddrW-1:0] regAddr;

	// Shift amount taken straight from the immediate field
	typedef logic [shiftAmtW-1:0] shiftAmt;

endpackage

// ==== design/issuePkg.sv ====
package issuePkg;

	// ALU operation code as decode hands it over
	typedef logic [3:0] aluCode;

	// Operand B source
	typedef enum logic [1:0]
	{
		// rs2 value from the register file
		selReg,
		// Immediate already sign-extended by decode
		selImm,
		// Shift amount, zero-extended
		selShamt
	} opBSel;

	// Decoded instruction offered to the issue stage
	typedef struct packed
	{
		logic valid;
		rvIsaPkg::regAddr rs1;
		logic usesRs1;
		rvIsaPkg::regAddr rs2;
		logic usesRs2;
		rvIsaPkg::regAddr rd;
		logic writeEn;
		opBSel bSel;
		rvIsaPkg::word imm;
		rvIsaPkg::shiftAmt shamt;
		aluCode aluFn;
		rvIsaPkg::word pc;
	} decodeBundle;

	// Instruction with its operands, as latched for execute
	typedef struct packed
	{
		logic valid;
		rvIsaPkg::word opA;
		rvIsaPkg::word opB;
		rvIsaPkg::regAddr rd;
		logic writeEn;
		aluCode aluFn;
		rvIsaPkg::word pc;
	} issueBundle;

	// Register write from the writeback stage
	typedef struct packed
	{
		logic writeEn;
		rvIsaPkg::regAddr rd;
		rvIsaPkg::word data;
	} wbBundle;

endpackage

// ==== design/regFile.sv ====
module regFile #(
	parameter int regCount = 32
) (
	input logic clk,
	input logic nrst,
	input issuePkg::wbBundle wb,
	input rvIsaPkg::regAddr rs1,
	input rvIsaPkg::regAddr rs2,
	output rvIsaPkg::word rdData1,
	output rvIsaPkg::word rdData2
);

	// Index width into the array is 4 bits for the embedded variant
	localparam int idxW = $clog2(regCount);

	typedef logic [idxW-1:0] regIdx;

	rvIsaPkg::word regs [regCount];

	regIdx wrIdx;
	logic wrHit;

	// Upper address bits dropped when regCount is 16
	assign wrIdx = wb.rd[idxW-1:0];

	// x0 never takes a write
	assign wrHit = wb.writeEn && (wrIdx != '0);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrHit)
		begin
			regs[wrIdx] <= wb.data;
		end
	end

	// Same read path for both ports
	// Write-through so a same-cycle writeback is seen at once
	function automatic rvIsaPkg::word readPort(input regIdx idx);
		rvIsaPkg::word value;
		if (idx == '0)
			value = '0;
		else if (wrHit && (wrIdx == idx))
			value = wb.data;
		else
			value = regs[idx];
		return value;
	endfunction

	always_comb
	begin
		rdData1 = readPort(rs1[idxW-1:0]);
		rdData2 = readPort(rs2[idxW-1:0]);
	end

endmodule

// ==== design/hazardScoreboard.sv ====
module hazardScoreboard #(
	parameter int regCount = 32
) (
	input logic clk,
	input logic nrst,
	input issuePkg::decodeBundle dec,
	input logic fire,
	input issuePkg::wbBundle wb,
	output logic hazard
);

	localparam int idxW = $clog2(regCount);

	typedef logic [idxW-1:0] regIdx;

	// One bit per register, set while a result is still in flight
	logic [regCount-1:0] busy;

	// Bits to set at this edge and bits to clear
	logic [regCount-1:0] setMask;
	logic [regCount-1:0] clrMask;

	// Busy view seen by decode this cycle
	logic [regCount-1:0] busyNow;

	regIdx rs1Idx;
	regIdx rs2Idx;
	regIdx rdIdx;
	regIdx wbIdx;

	logic rs1Busy;
	logic rs2Busy;
	logic rdBusy;

	assign rs1Idx = dec.rs1[idxW-1:0];
	assign rs2Idx = dec.rs2[idxW-1:0];
	assign rdIdx = dec.rd[idxW-1:0];
	assign wbIdx = wb.rd[idxW-1:0];

	always_comb
	begin
		setMask = '0;
		clrMask = '0;
		// Accepted writer claims its destination
		if (fire && dec.writeEn)
			setMask[rdIdx] = 1'b1;
		// Writeback releases it
		if (wb.writeEn)
			clrMask[wbIdx] = 1'b1;
		// x0 stays free either way
		setMask[0] = 1'b0;
		clrMask[0] = 1'b0;
	end

	// A register written back this cycle is already free,
	// its data reaches the reader through the register file bypass
	assign busyNow = busy & ~clrMask;

	assign rs1Busy = dec.usesRs1 && busyNow[rs1Idx];
	assign rs2Busy = dec.usesRs2 && busyNow[rs2Idx];

	// WAW check on the destination
	assign rdBusy = dec.writeEn && busyNow[rdIdx];

	assign hazard = dec.valid && (rs1Busy || rs2Busy || rdBusy);

	// Set applied after clear so a new claim wins on the same register
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			busy <= '0;
		else
			busy <= (busy & ~clrMask) | setMask;
	end

endmodule

// ==== design/operandIssue.sv ====
module operandIssue (
	input logic clk,
	input logic nrst,
	input issuePkg::decodeBundle dec,
	input rvIsaPkg::word rdData1,
	input rvIsaPkg::word rdData2,
	input logic hazard,
	input logic branchTaken,
	input logic memBusy,
	output logic fire,
	output logic stall,
	output issuePkg::issueBundle exOut
);

	// Control part of the issue register
	logic validQ;
	logic writeEnQ;
	rvIsaPkg::regAddr rdQ;

	// Payload part
	rvIsaPkg::word opAQ;
	rvIsaPkg::word opBQ;
	issuePkg::aluCode aluFnQ;
	rvIsaPkg::word pcQ;

	// Operand B after the source mux
	rvIsaPkg::word opBSelected;

	// Memory back-pressure freezes everything.
	// A killed bundle is dropped, so decode must not wait on it
	assign stall = memBusy || (hazard && !branchTaken);

	assign fire = dec.valid && !memBusy && !branchTaken && !hazard;

	always_comb
	begin
		unique case (dec.bSel)
			issuePkg::selReg:
				opBSelected = rdData2;
			issuePkg::selImm:
				opBSelected = dec.imm;
			issuePkg::selShamt:
				opBSelected = rvIsaPkg::word'(dec.shamt);
			default:
				opBSelected = rdData2;
		endcase
	end

	// Control fields
	// Held under memBusy, cleared to a bubble when nothing fires
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			validQ <= 1'b0;
			writeEnQ <= 1'b0;
			rdQ <= '0;
		end
		else if (!memBusy)
		begin
			validQ <= fire;
			writeEnQ <= fire && dec.writeEn;
			rdQ <= fire ? dec.rd : '0;
		end
	end

	// Payload only moves with an accepted instruction
	always_ff @(posedge clk)
	begin
		if (fire)
		begin
			opAQ <= rdData1;
			opBQ <= opBSelected;
			aluFnQ <= dec.aluFn;
			pcQ <= dec.pc;
		end
	end

	always_comb
	begin
		exOut.valid = validQ;
		exOut.opA = opAQ;
		exOut.opB = opBQ;
		exOut.rd = rdQ;
		exOut.writeEn = writeEnQ;
		exOut.aluFn = aluFnQ;
		exOut.pc = pcQ;
	end

endmodule

// ==== design/issueTop.sv ====
module issueTop #(
	parameter int regCount = 32
) (
	input logic clk,
	input logic nrst,
	input issuePkg::decodeBundle decIn,
	input issuePkg::wbBundle wbIn,
	input logic branchTaken,
	input logic memBusy,
	output logic stall,
	output issuePkg::issueBundle exOut
);

	// Operands read for the instruction at decode
	rvIsaPkg::word rdData1;
	rvIsaPkg::word rdData2;

	// Scoreboard verdict and acceptance pulse
	logic hazard;
	logic fire;

	// Register file, read side driven straight from decode
	regFile #(
		.regCount(regCount)
	) i_regFile (
		.clk(clk),
		.nrst(nrst),
		.wb(wbIn),
		.rs1(decIn.rs1),
		.rs2(decIn.rs2),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

	// Busy tracking, looks at the same bundle in parallel
	hazardScoreboard #(
		.regCount(regCount)
	) i_hazardScoreboard (
		.clk(clk),
		.nrst(nrst),
		.dec(decIn),
		.fire(fire),
		.wb(wbIn),
		.hazard(hazard)
	);

	// Acceptance, operand B mux and the issue register
	operandIssue i_operandIssue (
		.clk(clk),
		.nrst(nrst),
		.dec(decIn),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.hazard(hazard),
		.branchTaken(branchTaken),
		.memBusy(memBusy),
		.fire(fire),
		.stall(stall),
		.exOut(exOut)
	);

endmodule

// ==== dv/issueTests.svh ====
// Idle after reset and zero reads of x0 and x1
task automatic afterReset();
	issuePkg::decodeBundle d;
	@(negedge clk);
	checkFlag("stall", stall, 1'b0);
	checkFlag("exOut.valid", exOut.valid, 1'b0);
	nextCycle();
	d = makeDec(5'd0, 5'd1, 5'd3, 1'b0, issuePkg::selReg);
	issueOne(d);
	if (!accepted)
		return;
	@(negedge clk);
	checkWord("exOut.opA", exOut.opA, '0);
	checkWord("exOut.opB", exOut.opB, '0);
	checkIssue("exOut", exOut, expectIssue(d));
	nextCycle();
	reportTest("afterReset");
endtask

// One bundle per operand B source
task automatic operandSelect();
	issuePkg::decodeBundle d;
	writeBack(5'd6, $urandom());
	writeBack(5'd7, $urandom());
	for (int k = 0; k < 3; k++)
	begin
		d = makeDec(5'd6, 5'd7, rvIsaPkg::regAddr'(20 + k), 1'b0, issuePkg::opBSel'(k));
		issueOne(d);
		if (!accepted)
			return;
		@(negedge clk);
		checkIssue("exOut", exOut, expectIssue(d));
		nextCycle();
		// Only a bubble one cycle later
		@(negedge clk);
		checkFlag("exOut.valid", exOut.valid, 1'b0);
		nextCycle();
	end
	reportTest("operandSelect");
endtask

// RAW on r5 and WAW on r10
task automatic rawHazard();
	issuePkg::decodeBundle writer;
	issuePkg::decodeBundle reader;
	writer = makeDec(5'd1, 5'd0, 5'd5, 1'b1, issuePkg::selImm);
	reader = makeDec(5'd5, 5'd0, 5'd9, 1'b0, issuePkg::selImm);
	issueOne(writer);
	if (!accepted)
		return;
	decIn = reader;
	@(negedge clk);
	checkIssue("exOut", exOut, expectIssue(writer));
	checkFlag("stall", stall, 1'b1);
	repeat (4)
	begin
		nextCycle();
		@(negedge clk);
		checkFlag("stall", stall, 1'b1);
		checkFlag("exOut.valid", exOut.valid, 1'b0);
	end
	nextCycle();
	// Reader goes on the writeback edge through the bypass
	writeBack(5'd5, $urandom());
	decIn.valid = 1'b0;
	@(negedge clk);
	checkWord("exOut.opA", exOut.opA, model[5]);
	checkIssue("exOut", exOut, expectIssue(reader));
	nextCycle();
	writer = makeDec(5'd0, 5'd0, 5'd10, 1'b1, issuePkg::selImm);
	reader = makeDec(5'd0, 5'd0, 5'd10, 1'b1, issuePkg::selShamt);
	issueOne(writer);
	if (!accepted)
		return;
	decIn = reader;
	repeat (3)
	begin
		@(negedge clk);
		checkFlag("stall", stall, 1'b1);
		nextCycle();
	end
	writeBack(5'd10, $urandom());
	@(negedge clk);
	checkIssue("exOut", exOut, expectIssue(reader));
	// New claim on r10 beat the release in the same edge
	checkFlag("stall", stall, 1'b1);
	nextCycle();
	decIn.valid = 1'b0;
	writeBack(5'd10, $urandom());
	reportTest("rawHazard");
endtask

// Taken branch drops the bundle and its claim
task automatic killed();
	issuePkg::decodeBundle writer;
	issuePkg::decodeBundle reader;
	writer = makeDec(5'd0, 5'd0, 5'd11, 1'b1, issuePkg::selImm);
	reader = makeDec(5'd12, 5'd0, 5'd13, 1'b0, issuePkg::selImm);
	issueOne(writer);
	if (!accepted)
		return;
	// Waits on r11 so only the kill keeps stall low
	decIn = makeDec(5'd11, 5'd0, 5'd12, 1'b1, issuePkg::selImm);
	branchTaken = 1'b1;
	@(negedge clk);
	checkFlag("stall", stall, 1'b0);
	nextCycle();
	// Hazard gone so only the kill keeps it out
	decIn.rs1 = 5'd0;
	nextCycle();
	branchTaken = 1'b0;
	decIn.valid = 1'b0;
	@(negedge clk);
	checkFlag("exOut.valid", exOut.valid, 1'b0);
	nextCycle();
	writeBack(5'd11, $urandom());
	issueOne(reader);
	if (!accepted)
		return;
	if (stallCycles != 0)
	begin
		errCount++;
		$display("Reader of a killed destination stalled for %0d cycles", stallCycles);
	end
	@(negedge clk);
	checkIssue("exOut", exOut, expectIssue(reader));
	nextCycle();
	reportTest("killed");
endtask

// memBusy freezes exOut and the waiting bundle goes afterwards
task automatic memHold();
	issuePkg::decodeBundle first;
	issuePkg::decodeBundle second;
	first = makeDec(5'd6, 5'd7, 5'd14, 1'b0, issuePkg::selReg);
	second = makeDec(5'd7, 5'd6, 5'd15, 1'b0, issuePkg::selReg);
	issueOne(first);
	if (!accepted)
		return;
	memBusy = 1'b1;
	decIn = second;
	repeat (5)
	begin
		@(negedge clk);
		checkIssue("exOut", exOut, expectIssue(first));
		checkFlag("stall", stall, 1'b1);
		nextCycle();
	end
	memBusy = 1'b0;
	@(negedge clk);
	checkIssue("exOut", exOut, expectIssue(first));
	checkFlag("stall", stall, 1'b0);
	nextCycle();
	decIn.valid = 1'b0;
	@(negedge clk);
	checkIssue("exOut", exOut, expectIssue(second));
	nextCycle();
	reportTest("memHold");
endtask

// x0 is never busy and never written
task automatic regZero();
	issuePkg::decodeBundle d;
	d = makeDec(5'd0, 5'd0, 5'd0, 1'b1, issuePkg::selImm);
	issueOne(d);
	if (!accepted)
		return;
	@(negedge clk);
	checkIssue("exOut", exOut, expectIssue(d));
	nextCycle();
	// Would hit WAW if the first writer had left a busy bit
	issueOne(d);
	if (!accepted)
		return;
	if (stallCycles != 0)
	begin
		errCount++;
		$display("Writer of x0 left a busy bit behind");
	end
	writeBack(5'd0, $urandom());
	d = makeDec(5'd0, 5'd0, 5'd16, 1'b0, issuePkg::selReg);
	issueOne(d);
	if (!accepted)
		return;
	@(negedge clk);
	checkWord("exOut.opA", exOut.opA, '0);
	checkWord("exOut.opB", exOut.opB, '0);
	nextCycle();
	reportTest("regZero");
endtask

// ==== dv/issueTb.sv ====
module issueTb;

	localparam int regCount = 32;
	// Cycles any wait may take before the run gives up
	localparam int waitLimit = 40;

	logic clk;
	logic nrst;
	issuePkg::decodeBundle decIn;
	issuePkg::wbBundle wbIn;
	logic branchTaken;
	logic memBusy;
	logic stall;
	issuePkg::issueBundle exOut;

	// Register contents as the writeback rules predict them
	rvIsaPkg::word model [regCount];

	int errCount;
	int errMark;
	int testCount;
	bit timedOut;

	// Outcome of the last issue attempt
	bit accepted;
	int stallCycles;

	issueTop #(
		.regCount(regCount)
	) i_issueTop (
		.clk(clk),
		.nrst(nrst),
		.decIn(decIn),
		.wbIn(wbIn),
		.branchTaken(branchTaken),
		.memBusy(memBusy),
		.stall(stall),
		.exOut(exOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Inputs change 1 unit after the rising edge
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic checkIssue(input string name, input issuePkg::issueBundle got,
		input issuePkg::issueBundle exp);
		if (got !== exp)
		begin
			errCount++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkWord(input string name, input rvIsaPkg::word got,
		input rvIsaPkg::word exp);
		if (got !== exp)
		begin
			errCount++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errCount++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Decoded bundle with random payload fields
	function automatic issuePkg::decodeBundle makeDec(input rvIsaPkg::regAddr rs1,
		input rvIsaPkg::regAddr rs2, input rvIsaPkg::regAddr rd, input logic writeEn,
		input issuePkg::opBSel bSel);
		issuePkg::decodeBundle d;
		d.valid = 1'b1;
		d.rs1 = rs1;
		d.usesRs1 = 1'b1;
		d.rs2 = rs2;
		// rs2 only matters when it feeds operand B
		d.usesRs2 = (bSel == issuePkg::selReg);
		d.rd = rd;
		d.writeEn = writeEn;
		d.bSel = bSel;
		d.imm = $urandom();
		d.shamt = rvIsaPkg::shiftAmt'($urandom());
		d.aluFn = issuePkg::aluCode'($urandom());
		d.pc = $urandom() & 32'hffff_fffc;
		return d;
	endfunction

	// What execute should see one edge after acceptance
	function automatic issuePkg::issueBundle expectIssue(input issuePkg::decodeBundle d);
		issuePkg::issueBundle e;
		e.valid = 1'b1;
		e.opA = model[d.rs1];
		if (d.bSel == issuePkg::selImm)
			e.opB = d.imm;
		else if (d.bSel == issuePkg::selShamt)
			e.opB = {27'b0, d.shamt};
		else
			e.opB = model[d.rs2];
		e.rd = d.rd;
		e.writeEn = d.writeEn;
		e.aluFn = d.aluFn;
		e.pc = d.pc;
		return e;
	endfunction

	// One writeback cycle, x0 keeps its zero
	task automatic writeBack(input rvIsaPkg::regAddr rd, input rvIsaPkg::word data);
		wbIn.writeEn = 1'b1;
		wbIn.rd = rd;
		wbIn.data = data;
		if (rd != '0)
			model[rd] = data;
		nextCycle();
		wbIn = '0;
	endtask

	// Present d until stall drops, returns just after the acceptance edge
	task automatic issueOne(input issuePkg::decodeBundle d);
		accepted = 1'b0;
		stallCycles = 0;
		decIn = d;
		while (!accepted && stallCycles < waitLimit)
		begin
			@(negedge clk);
			if (!stall)
				accepted = 1'b1;
			else
				stallCycles++;
		end
		nextCycle();
		decIn.valid = 1'b0;
		if (!accepted)
		begin
			timedOut = 1'b1;
			$display("Timeout: instruction at pc %h was never accepted", d.pc);
		end
	endtask

	task automatic reportTest(input string name);
		testCount++;
		if (errCount == errMark)
			$display("Test %s: passed", name);
		else
			$display("Test %s: failed with %0d errors", name, errCount - errMark);
		errMark = errCount;
	endtask

	`include "issueTests.svh"

	initial
	begin
		void'($urandom(32'h1997));
		errCount = 0;
		errMark = 0;
		testCount = 0;
		timedOut = 1'b0;
		nrst = 1'b0;
		decIn = '0;
		wbIn = '0;
		branchTaken = 1'b0;
		memBusy = 1'b0;
		for (int i = 0; i < regCount; i++)
			model[i] = '0;
		repeat (16) @(posedge clk);
		#1;
		nrst = 1'b1;
		if (!timedOut)
			afterReset();
		if (!timedOut)
			operandSelect();
		if (!timedOut)
			rawHazard();
		if (!timedOut)
			killed();
		if (!timedOut)
			memHold();
		if (!timedOut)
			regZero();
		$display("Tests run %0d, failed checks %0d", testCount, errCount);
		if (errCount == 0 && !timedOut)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+dv
design/rvIsaPkg.sv
design/issuePkg.sv
design/regFile.sv
design/hazardScoreboard.sv
design/operandIssue.sv
design/issueTop.sv
dv/issueTb.sv

// ==== Makefile ====
# Verilator build and run of the issue stage testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f sources.f --top-module issueTb -Mdir obj_dir -o issueSim
	./obj_dir/issueSim | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
